// File: compile.f
verilog/frame_fifo_pkg.sv
verilog/frame_write_ctrl.sv
verilog/frame_ram.sv
verilog/frame_read_ctrl.sv
verilog/frame_fifo_top.sv
sim/frame_fifo_properties.sv
sim/frame_fifo_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vframe_fifo_tb: compile.f verilog/*.sv sim/*.sv
	verilator --binary --timing --assert --top-module frame_fifo_tb -f compile.f

run: obj_dir/Vframe_fifo_tb
	./obj_dir/Vframe_fifo_tb | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation incomplete"; exit 1)

lint:
	verilator --lint-only -Wall --top-module frame_fifo_top \
		verilog/frame_fifo_pkg.sv \
		verilog/frame_write_ctrl.sv \
		verilog/frame_ram.sv \
		verilog/frame_read_ctrl.sv \
		verilog/frame_fifo_top.sv

clean:
	rm -rf obj_dir sim.log

// File: sim/frame_fifo_tb.sv
module frame_fifo_tb
    import frame_fifo_pkg::*;
();

    localparam int in_period     = 10;
    localparam int out_period    = 8;
    localparam int reset_cycles  = 5;
    localparam int max_frame_len = 20;
    localparam int oversize_len  = fifo_depth + 5;

    localparam int frames_basic    = 30;
    localparam int frames_pressure = 30;
    localparam int frames_fill     = 10;

    // one beat as seen on the stream, last on top
    localparam int beat_bits = 1 + keep_width + data_width;

    localparam int outcome_good     = 0;
    localparam int outcome_bad      = 1;
    localparam int outcome_overflow = 2;

    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_hold   = 2;

    typedef logic [beat_bits-1:0] beat_t;
    typedef beat_t beat_q_t[$];

    logic                  input_clk;
    logic                  input_rst_sync2;
    logic                  output_clk;
    logic                  output_rst_sync2;

    logic [data_width-1:0] input_axis_tdata;
    logic [keep_width-1:0] input_axis_tkeep;
    logic                  input_axis_tvalid;
    logic                  input_axis_tready;
    logic                  input_axis_tlast;
    logic                  input_axis_tuser;

    logic [data_width-1:0] output_axis_tdata;
    logic [keep_width-1:0] output_axis_tkeep;
    logic                  output_axis_tvalid;
    logic                  output_axis_tready;
    logic                  output_axis_tlast;

    logic                  overflow;
    logic                  bad_frame;
    logic                  good_frame;

    beat_t expected_q[$];
    int    good_expected;
    int    bad_expected;
    int    overflow_expected;
    int    good_seen;
    int    bad_seen;
    int    overflow_seen;
    int    ready_mode;
    logic  fill_sending;
    string test_name;

    frame_fifo_top frame_fifo_top_inst (.*);

    initial begin
        output_clk = 1'b0;
        forever #(out_period / 2) output_clk = ~output_clk;
    end

    initial begin
        input_clk = 1'b0;
        forever #(in_period / 2) input_clk = ~input_clk;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    // a committed frame comes out whole, a rolled back or oversize one not at all
    function automatic int model_frame(input beat_q_t frame, input logic user_flag,
                                       output beat_q_t expected);
        expected = {};
        if (frame.size() > fifo_depth) begin
            return outcome_overflow;
        end
        if (user_flag) begin
            return outcome_bad;
        end
        expected = frame;
        return outcome_good;
    endfunction

    function automatic void make_frame(input int len, output beat_q_t frame);
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        frame = {};
        for (int i = 0; i < len; i++) begin
            data = {$urandom, $urandom};
            keep = keep_width'($urandom);
            frame.push_back({i == len - 1, keep, data});
        end
    endfunction

    // entered on a falling input_clk edge, left on one
    task automatic send_beat(input beat_t beat, input logic user_flag);
        logic accepted;
        {input_axis_tlast, input_axis_tkeep, input_axis_tdata} = beat;
        input_axis_tuser  = user_flag;
        input_axis_tvalid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            // ready only changes on a rising edge, so this is its value at the next one
            accepted = input_axis_tready;
            @(negedge input_clk);
        end
    endtask

    task automatic send_frame(input beat_q_t frame, input logic user_flag);
        beat_q_t expected;
        int      outcome;
        outcome = model_frame(frame, user_flag, expected);
        foreach (expected[i]) begin
            expected_q.push_back(expected[i]);
        end
        case (outcome)
            outcome_good: good_expected++;
            outcome_bad:  bad_expected++;
            default:      overflow_expected++;
        endcase
        foreach (frame[i]) begin
            send_beat(frame[i], user_flag && (i == frame.size() - 1));
        end
    endtask

    task automatic go_idle();
        input_axis_tvalid = 1'b0;
        input_axis_tlast  = 1'b0;
        input_axis_tuser  = 1'b0;
    endtask

    task automatic start_test(input string name, input int mode);
        test_name = name;
        // away from the falling output edge where ready is driven
        @(posedge output_clk);
        ready_mode = mode;
        @(negedge input_clk);
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) begin
            @(posedge output_clk);
        end
        // late status pulses and stray beats
        repeat (10) @(negedge input_clk);
        check_value({test_name, " good_frame pulses"}, 128'(good_expected), 128'(good_seen));
        check_value({test_name, " bad_frame pulses"}, 128'(bad_expected), 128'(bad_seen));
        check_value({test_name, " overflow pulses"}, 128'(overflow_expected),
                    128'(overflow_seen));
    endtask

    task automatic wait_for_stall();
        logic stalled;
        stalled = 1'b0;
        while (!stalled && fill_sending) begin
            @(negedge input_clk);
            stalled = input_axis_tvalid && !input_axis_tready;
        end
        if (!stalled) begin
            $display("input ready never went low while the output was held off");
            abort_run();
        end
    endtask

    initial begin : drive_output_ready
        forever begin
            @(negedge output_clk);
            case (ready_mode)
                ready_random: output_axis_tready = ($urandom % 2) == 0;
                ready_hold:   output_axis_tready = 1'b0;
                default:      output_axis_tready = 1'b1;
            endcase
        end
    end

    initial begin : compare_output
        beat_t expected;
        forever begin
            @(posedge output_clk);
            if (output_axis_tvalid && output_axis_tready) begin
                if (expected_q.size() == 0) begin
                    $display("output beat arrived in %s with no beat expected", test_name);
                    abort_run();
                end else begin
                    expected = expected_q.pop_front();
                    check_value({test_name, " tdata"}, 128'(expected[data_width-1:0]),
                                128'(output_axis_tdata));
                    check_value({test_name, " tkeep"}, 128'(expected[data_width +: keep_width]),
                                128'(output_axis_tkeep));
                    check_value({test_name, " tlast"}, 128'(expected[beat_bits-1]),
                                128'(output_axis_tlast));
                end
            end
        end
    end

    // status pulses are one input_clk cycle wide
    initial begin : count_status
        forever begin
            @(posedge input_clk);
            if (good_frame) good_seen++;
            if (bad_frame) bad_seen++;
            if (overflow) overflow_seen++;
        end
    end

    initial begin : watchdog
        int     max_beats;
        longint limit;
        max_beats = (frames_basic + frames_pressure + frames_fill + 4) * max_frame_len
                    + oversize_len;
        // back-pressure and the fill stall slow the drain, several cycles per beat
        limit = longint'(max_beats) * 6 * in_period + 2000 * in_period;
        #(limit);
        $display("run timed out after %0d time units with frames still in flight", limit);
        abort_run();
    end

    initial begin : main_sequence
        beat_q_t frame;
        logic    user_flag;

        void'($urandom(93));
        input_axis_tdata   = '0;
        input_axis_tkeep   = '0;
        input_axis_tvalid  = 1'b0;
        input_axis_tlast   = 1'b0;
        input_axis_tuser   = 1'b0;
        output_axis_tready = 1'b0;
        input_rst_sync2    = 1'b1;
        output_rst_sync2   = 1'b1;
        ready_mode         = ready_always;
        fill_sending       = 1'b0;
        test_name          = "reset";

        fork
            begin
                repeat (reset_cycles) @(posedge input_clk);
                @(negedge input_clk);
                input_rst_sync2 = 1'b0;
            end
            begin
                repeat (reset_cycles) @(posedge output_clk);
                @(negedge output_clk);
                output_rst_sync2 = 1'b0;
            end
        join

        start_test("good_frames", ready_always);
        repeat (frames_basic) begin
            make_frame(1 + int'($urandom % max_frame_len), frame);
            send_frame(frame, 1'b0);
        end
        go_idle();
        wait_drained();

        // error frame between two clean ones
        start_test("bad_frame", ready_always);
        make_frame(1 + int'($urandom % max_frame_len), frame);
        send_frame(frame, 1'b0);
        make_frame(1 + int'($urandom % max_frame_len), frame);
        send_frame(frame, 1'b1);
        make_frame(1 + int'($urandom % max_frame_len), frame);
        send_frame(frame, 1'b0);
        go_idle();
        wait_drained();

        start_test("oversize_frame", ready_always);
        make_frame(oversize_len, frame);
        send_frame(frame, 1'b0);
        make_frame(1 + int'($urandom % max_frame_len), frame);
        send_frame(frame, 1'b0);
        go_idle();
        wait_drained();

        start_test("back_pressure", ready_random);
        repeat (frames_pressure) begin
            make_frame(1 + int'($urandom % max_frame_len), frame);
            user_flag = ($urandom % 4) == 0;
            send_frame(frame, user_flag);
        end
        go_idle();
        wait_drained();

        // sink held off until the writer stalls on a full buffer
        start_test("buffer_full", ready_hold);
        fill_sending = 1'b1;
        fork
            begin
                repeat (frames_fill) begin
                    make_frame(10 + int'($urandom % 11), frame);
                    send_frame(frame, 1'b0);
                end
                go_idle();
                fill_sending = 1'b0;
            end
            begin
                wait_for_stall();
                repeat (20) @(negedge input_clk);
                @(posedge output_clk);
                ready_mode = ready_always;
            end
        join
        wait_drained();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: sim/frame_fifo_properties.sv
module frame_fifo_properties (
    input logic output_clk,
    input logic output_rst_sync2,
    input logic output_axis_tvalid,
    input logic output_axis_tready,
    input logic mem_rd_en
);

    // async reset clears the output register valid
    valid_low_in_reset: assert property (
        @(posedge output_clk) output_rst_sync2 |-> !output_axis_tvalid
    ) else $error("output valid high during reset");

    // a stalled beat stays offered
    valid_held_on_stall: assert property (
        @(posedge output_clk) disable iff (output_rst_sync2)
        (output_axis_tvalid && !output_axis_tready) |=> output_axis_tvalid
    ) else $error("output valid dropped while the sink stalled");

    // no read may overwrite a stalled beat
    no_read_on_stall: assert property (
        @(posedge output_clk) disable iff (output_rst_sync2)
        !(mem_rd_en && output_axis_tvalid && !output_axis_tready)
    ) else $error("memory read while the output register was stalled");

endmodule

bind frame_read_ctrl frame_fifo_properties frame_fifo_properties_inst (
    .output_clk         (output_clk),
    .output_rst_sync2   (output_rst_sync2),
    .output_axis_tvalid (output_axis_tvalid),
    .output_axis_tready (output_axis_tready),
    .mem_rd_en          (mem_rd_en)
);

// File: verilog/frame_fifo_top.sv
module frame_fifo_top
    import frame_fifo_pkg::*;
(
    input  logic                  input_clk,
    input  logic                  input_rst_sync2,
    input  logic                  output_clk,
    input  logic                  output_rst_sync2,

    // write side
    input  logic [data_width-1:0] input_axis_tdata,
    input  logic [keep_width-1:0] input_axis_tkeep,
    input  logic                  input_axis_tvalid,
    output logic                  input_axis_tready,
    input  logic                  input_axis_tlast,
    input  logic                  input_axis_tuser,

    // read side
    output logic [data_width-1:0] output_axis_tdata,
    output logic [keep_width-1:0] output_axis_tkeep,
    output logic                  output_axis_tvalid,
    input  logic                  output_axis_tready,
    output logic                  output_axis_tlast,

    // write domain status
    output logic                  overflow,
    output logic                  bad_frame,
    output logic                  good_frame
);

    logic [ptr_width-1:0]   wr_ptr_gray;
    logic [ptr_width-1:0]   rd_ptr_gray;

    logic                   mem_wr_en;
    logic [addr_width-1:0]  mem_wr_addr;
    logic [entry_width-1:0] mem_wr_entry;

    logic                   mem_rd_en;
    logic [addr_width-1:0]  mem_rd_addr;
    logic [entry_width-1:0] rd_entry;

    frame_write_ctrl frame_write_ctrl_inst (
        .input_clk         (input_clk),
        .input_rst_sync2   (input_rst_sync2),
        .input_axis_tdata  (input_axis_tdata),
        .input_axis_tkeep  (input_axis_tkeep),
        .input_axis_tvalid (input_axis_tvalid),
        .input_axis_tlast  (input_axis_tlast),
        .input_axis_tuser  (input_axis_tuser),
        .input_axis_tready (input_axis_tready),
        .rd_ptr_gray       (rd_ptr_gray),
        .wr_ptr_gray       (wr_ptr_gray),
        .mem_wr_en         (mem_wr_en),
        .mem_wr_addr       (mem_wr_addr),
        .mem_wr_entry      (mem_wr_entry),
        .overflow          (overflow),
        .bad_frame         (bad_frame),
        .good_frame        (good_frame)
    );

    frame_ram frame_ram_inst (
        .input_clk  (input_clk),
        .wr_en      (mem_wr_en),
        .wr_addr    (mem_wr_addr),
        .wr_entry   (mem_wr_entry),
        .output_clk (output_clk),
        .rd_en      (mem_rd_en),
        .rd_addr    (mem_rd_addr),
        .rd_entry   (rd_entry)
    );

    frame_read_ctrl frame_read_ctrl_inst (
        .output_clk         (output_clk),
        .output_rst_sync2   (output_rst_sync2),
        .wr_ptr_gray        (wr_ptr_gray),
        .rd_ptr_gray        (rd_ptr_gray),
        .output_axis_tready (output_axis_tready),
        .output_axis_tvalid (output_axis_tvalid),
        .mem_rd_en          (mem_rd_en),
        .mem_rd_addr        (mem_rd_addr)
    );

    // registered entry straight onto the output stream
    assign {output_axis_tlast, output_axis_tkeep, output_axis_tdata} = rd_entry;

endmodule

// File: verilog/frame_read_ctrl.sv
module frame_read_ctrl
    import frame_fifo_pkg::*;
(
    input  logic                  output_clk,
    input  logic                  output_rst_sync2,

    input  logic [ptr_width-1:0]  wr_ptr_gray,
    output logic [ptr_width-1:0]  rd_ptr_gray,

    input  logic                  output_axis_tready,
    output logic                  output_axis_tvalid,

    output logic                  mem_rd_en,
    output logic [addr_width-1:0] mem_rd_addr
);

    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] rd_ptr_next;

    logic [ptr_width-1:0] wr_ptr_gray_sync1;
    logic [ptr_width-1:0] wr_ptr_gray_sync2;

    logic empty;
    // output register free or being taken this cycle
    logic out_free;

    // committed write pointer into the read clock domain
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            wr_ptr_gray_sync1 <= '0;
            wr_ptr_gray_sync2 <= '0;
        end else begin
            wr_ptr_gray_sync1 <= wr_ptr_gray;
            wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
        end
    end

    // nothing committed beyond our own pointer
    assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

    assign out_free    = output_axis_tready | ~output_axis_tvalid;
    assign mem_rd_en   = out_free & ~empty;
    assign mem_rd_addr = rd_ptr[addr_width-1:0];
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (mem_rd_en) begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
        end
    end

    // valid follows the read decision, held while the sink stalls
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            output_axis_tvalid <= 1'b0;
        end else if (out_free) begin
            output_axis_tvalid <= ~empty;
        end
    end

endmodule

// File: verilog/frame_ram.sv
module frame_ram
    import frame_fifo_pkg::*;
(
    // write port
    input  logic                   input_clk,
    input  logic                   wr_en,
    input  logic [addr_width-1:0]  wr_addr,
    input  logic [entry_width-1:0] wr_entry,

    // read port
    input  logic                   output_clk,
    input  logic                   rd_en,
    input  logic [addr_width-1:0]  rd_addr,
    output logic [entry_width-1:0] rd_entry
);

    // entry storage, one frame beat per word
    logic [entry_width-1:0] mem [fifo_depth];

    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // registered read, doubles as the output data register
    // holds its word while the sink stalls
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/frame_write_ctrl.sv
module frame_write_ctrl
    import frame_fifo_pkg::*;
(
    input  logic                   input_clk,
    input  logic                   input_rst_sync2,

    input  logic [data_width-1:0]  input_axis_tdata,
    input  logic [keep_width-1:0]  input_axis_tkeep,
    input  logic                   input_axis_tvalid,
    input  logic                   input_axis_tlast,
    input  logic                   input_axis_tuser,
    output logic                   input_axis_tready,

    input  logic [ptr_width-1:0]   rd_ptr_gray,
    output logic [ptr_width-1:0]   wr_ptr_gray,

    output logic                   mem_wr_en,
    output logic [addr_width-1:0]  mem_wr_addr,
    output logic [entry_width-1:0] mem_wr_entry,

    output logic                   overflow,
    output logic                   bad_frame,
    output logic                   good_frame
);

    // committed pointer, only moves on a good last beat
    logic [ptr_width-1:0] wr_ptr;
    // pointer of the frame being written
    logic [ptr_width-1:0] wr_ptr_cur;
    logic [ptr_width-1:0] wr_ptr_inc;
    logic [ptr_width-1:0] wr_ptr_cur_gray;

    logic [ptr_width-1:0] rd_ptr_gray_sync1;
    logic [ptr_width-1:0] rd_ptr_gray_sync2;

    // rest of the current frame is thrown away
    logic drop_frame;

    logic full;
    logic full_cur;
    logic write;

    // beat decode
    logic beat_drop;
    logic beat_store;
    logic beat_commit;
    logic beat_rollback;

    // read pointer into the write clock domain
    always_ff @(posedge input_clk or posedge input_rst_sync2) begin
        if (input_rst_sync2) begin
            rd_ptr_gray_sync1 <= '0;
            rd_ptr_gray_sync2 <= '0;
        end else begin
            rd_ptr_gray_sync1 <= rd_ptr_gray;
            rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
        end
    end

    assign wr_ptr_inc      = wr_ptr_cur + 1'b1;
    assign wr_ptr_cur_gray = wr_ptr_cur ^ (wr_ptr_cur >> 1);

    // gray full test, two msbs differ and the rest match
    assign full = (wr_ptr_cur_gray[addr_width] != rd_ptr_gray_sync2[addr_width]) &&
                  (wr_ptr_cur_gray[addr_width-1] != rd_ptr_gray_sync2[addr_width-1]) &&
                  (wr_ptr_cur_gray[addr_width-2:0] == rd_ptr_gray_sync2[addr_width-2:0]);

    // current frame alone covers every entry
    assign full_cur = (wr_ptr_cur[addr_width] != wr_ptr[addr_width]) &&
                      (wr_ptr_cur[addr_width-1:0] == wr_ptr[addr_width-1:0]);

    // an oversize or already dropped frame keeps flowing so it can be discarded,
    // otherwise a full buffer would hold it forever
    assign input_axis_tready = ~full | full_cur | drop_frame | drop_when_full;
    assign write = input_axis_tvalid & input_axis_tready;

    assign beat_drop     = write & (full | full_cur | drop_frame);
    assign beat_store    = write & ~beat_drop;
    assign beat_commit   = beat_store & input_axis_tlast & ~input_axis_tuser;
    assign beat_rollback = beat_store & input_axis_tlast & input_axis_tuser;

    // memory write port
    assign mem_wr_en    = beat_store;
    assign mem_wr_addr  = wr_ptr_cur[addr_width-1:0];
    assign mem_wr_entry = {input_axis_tlast, input_axis_tkeep, input_axis_tdata};

    always_ff @(posedge input_clk or posedge input_rst_sync2) begin
        if (input_rst_sync2) begin
            wr_ptr      <= '0;
            wr_ptr_cur  <= '0;
            wr_ptr_gray <= '0;
            drop_frame  <= 1'b0;
            overflow    <= 1'b0;
            bad_frame   <= 1'b0;
            good_frame  <= 1'b0;
        end else begin
            // status outputs are single cycle pulses
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;

            if (beat_drop) begin
                if (input_axis_tlast) begin
                    // end of a dropped frame, back to the last commit
                    wr_ptr_cur <= wr_ptr;
                    drop_frame <= 1'b0;
                    overflow   <= 1'b1;
                end else begin
                    drop_frame <= 1'b1;
                end
            end else if (beat_rollback) begin
                wr_ptr_cur <= wr_ptr;
                bad_frame  <= 1'b1;
            end else if (beat_commit) begin
                // frame becomes visible to the reader here
                wr_ptr      <= wr_ptr_inc;
                wr_ptr_cur  <= wr_ptr_inc;
                wr_ptr_gray <= wr_ptr_inc ^ (wr_ptr_inc >> 1);
                good_frame  <= 1'b1;
            end else if (beat_store) begin
                wr_ptr_cur <= wr_ptr_inc;
            end
        end
    end

endmodule

// File: verilog/frame_fifo_pkg.sv
package frame_fifo_pkg;

    // entry address, 64 entries deep
    localparam int addr_width = 6;

    // pointers carry one extra bit so a wrap differs from equality
    localparam int ptr_width = addr_width + 1;

    localparam int fifo_depth = 2 ** addr_width;

    // stream data path
    localparam int data_width = 64;

    // one keep bit per data byte
    localparam int keep_width = data_width / 8;

    // stored entry layout, msb first
    //   [entry_width-1]           last
    //   [data_width +: keep_width] keep
    //   [data_width-1:0]          data
    localparam int entry_width = 1 + keep_width + data_width;

    // full buffer policy
    // set: input ready stays high and beats that find the buffer full are dropped
    // clear: a full buffer holds input ready low until the reader frees space
    localparam logic drop_when_full = 1'b0;

endpackage
